// ==== sim.f ====
+incdir+source
source/core_pkg.sv
source/gpr_if.sv
source/gpr.sv
source/inst_decoder.sv
source/alu.sv
source/apb_issue_port.sv
source/exec_top.sv
verif/tb_clock.sv
verif/exec_assertions.sv
verif/tb_top.sv

// ==== verif/exec_stimulus.txt ====
# op addr data expect err (hex fields)
# W write  R read  B read straight after the previous transfer
W 00 00500093 00000000 0
W 00 ffd00113 00000000 0
W 00 123451b7 00000000 0
R 84 00000000 00000005 0
R 88 00000000 fffffffd 0
R 8c 00000000 12345000 0
W 00 00208233 00000000 0
B 90 00000000 00000002 0
W 00 402082b3 00000000 0
W 00 0020c333 00000000 0
W 00 002063b3 00000000 0
W 00 0020f433 00000000 0
W 00 001124b3 00000000 0
W 00 00113533 00000000 0
R 94 00000000 00000008 0
R 98 00000000 fffffff8 0
R 9c 00000000 fffffffd 0
R a0 00000000 00000005 0
R a4 00000000 00000001 0
R a8 00000000 00000000 0
W 00 001195b3 00000000 0
W 00 40115633 00000000 0
W 00 001156b3 00000000 0
W 00 00409713 00000000 0
W 00 40115793 00000000 0
W 00 00c1d813 00000000 0
R ac 00000000 468a0000 0
R b0 00000000 ffffffff 0
R b4 00000000 07ffffff 0
R b8 00000000 00000050 0
R bc 00000000 fffffffe 0
R c0 00000000 00012345 0
W 00 00708013 00000000 0
R 80 00000000 00000000 0
W 00 00002083 00000000 1
W 00 022080b3 00000000 1
R 84 00000000 00000005 0
W 40 00000000 00000000 1
W 04 00000001 00000000 1
R 04 00000000 00000011 0

// ==== verif/tb_top.sv ====
// Testbench top with stimulus reader, APB driver, result checks and timeout
`timescale 1ns/1ns
`include "core_settings.svh"

module tb_top;

    logic                    clk;
    logic                    rst_n;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [`CORE_APB_AW-1:0] paddr;
    logic [`CORE_XLEN-1:0]   pwdata;
    logic [`CORE_XLEN-1:0]   prdata;
    logic                    pready;
    logic                    pslverr;

    // One stimulus entry per data line
    byte                     st_op[$];
    logic [`CORE_APB_AW-1:0] st_addr[$];
    logic [`CORE_XLEN-1:0]   st_data[$];
    logic [`CORE_XLEN-1:0]   st_exp[$];
    logic                    st_err[$];

    logic [31:0] lfsr_state  = 32'd89850;
    int          cycle_count = 0;
    int          cycle_limit = 0;        // Set once the file is loaded
    int          checks_run  = 0;

    tb_clock u_clock (.*);
    exec_top DUT (.*);

    // Checker on the register bus and the retired counter
    bind exec_top exec_assertions u_chk (
        .clk     (clk),
        .rst_n   (rst_n),
        .pready  (pready),
        .pslverr (pslverr),
        .retired (u_port.retired_q),
        .rf      (rf_if.monitor)
    );

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks_run++;
        assert (actual === expected)
        else report_failure($sformatf("ERROR %s expected %h actual %h",
                                      name, expected, actual));
    endtask

    // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic next_idle(output int n);
        n = 0;
        repeat (2) begin                 // One step per bit taken
            n = (n << 1) | lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
        end
        n = n % 3;                       // 0 to 2 idle cycles
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            psel    = 1'b0;
            penable = 1'b0;
        end
    endtask

    // One APB transfer, setup then access, sampled at the completing edge
    task automatic apb_transfer(input logic wr, input logic [7:0] addr,
                                input logic [31:0] wdata,
                                output logic [31:0] rdata, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;                  // Access phase
        @(posedge clk);
        while (!pready) @(posedge clk);  // Wait states
        rdata = prdata;
        err   = pslverr;
    endtask

    initial begin
        int          fd;
        int          n;
        int          idle;
        string       line;
        byte         op;
        logic [7:0]  addr;
        logic [31:0] data;
        logic [31:0] expected;
        logic        err;
        logic [31:0] rdata;
        logic        got_err;

        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;

        fd = $fopen("verif/exec_stimulus.txt", "r");
        if (fd == 0) begin
            report_failure("Cannot open verif/exec_stimulus.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            n = $sscanf(line, "%c %h %h %h %h", op, addr, data, expected, err);
            if (n == 5) begin            // Comment and blank lines fall out here
                st_op.push_back(op);
                st_addr.push_back(addr);
                st_data.push_back(data);
                st_exp.push_back(expected);
                st_err.push_back(err);
            end
        end
        $fclose(fd);
        cycle_limit = st_op.size() * 8 + 50;

        wait (rst_n === 1'b1);
        @(posedge clk);                  // Idle bus just out of reset
        check_value("pready", 32'h1, pready);
        check_value("pslverr", 32'h0, pslverr);
        foreach (st_op[i]) begin
            if (st_op[i] != "B") begin   // B lines follow the last transfer directly
                next_idle(idle);
                idle_cycles(idle);
            end
            apb_transfer(st_op[i] == "W", st_addr[i], st_data[i], rdata, got_err);
            check_value("pslverr", st_err[i], got_err);
            if (st_op[i] != "W" && !st_err[i]) begin
                check_value("prdata", st_exp[i], rdata);
            end
        end
        idle_cycles(2);

        if (checks_run > 0 && DUT.u_chk.failures == 0) begin
            $display("All tests passed");
        end else begin
            $display("No checks ran or a bound assertion failed");
            $display("Some tests failed");
        end
        $finish;
    end

    // Cycle limit
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            report_failure("Timeout because the run exceeded its cycle limit");
        end
    end

endmodule

// ==== verif/exec_assertions.sv ====
// Concurrent checks on APB error response, register writes and retired counter
`timescale 1ns/1ns
`include "core_settings.svh"

module exec_assertions (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       pready,
    input logic                       pslverr,
    input logic [`CORE_RETIRED_W-1:0] retired,
    gpr_if.monitor                    rf
);

    int failures = 0;                    // Failed assertion count

    // Error response only on a completing access cycle
    a_slverr_ready: assert property (@(posedge clk) disable iff (!rst_n) pslverr |-> pready)
        else begin
            $error("pslverr high without pready");
            failures++;
        end

    // x0 never a write target
    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
                                    !(rf.we && (rf.wr_addr == '0)))
        else begin
            $error("register write enabled for x0");
            failures++;
        end

    // Counter only moves up
    a_retired_up: assert property (@(posedge clk) disable iff (!rst_n)
                                   retired >= $past(retired))
        else begin
            $error("retired counter decreased");
            failures++;
        end

endmodule

// ==== verif/tb_clock.sv ====
// Testbench clock generator with 40 ns period and three-cycle reset
`timescale 1ns/1ns

module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;          // 40 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);       // Three sampled reset edges
        @(negedge clk);
        rst_n = 1'b1;                    // Released away from the rising edge
    end

endmodule

// ==== source/exec_top.sv ====
// Execution slice top level with APB port, decoder, ALU and register file
`timescale 1ns/1ns
`include "core_settings.svh"

module exec_top (
    input  logic                    clk,
    input  logic                    rst_n,     // Synchronous, active low

    //////////////////////////////////////////////////////////////////////
    // APB slave
    //////////////////////////////////////////////////////////////////////
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [`CORE_APB_AW-1:0] paddr,
    input  logic [`CORE_XLEN-1:0]   pwdata,
    output logic [`CORE_XLEN-1:0]   prdata,
    output logic                    pready,    // Low one cycle during execute
    output logic                    pslverr
);

    // Register file bus
    gpr_if rf_if ();

    // Issue, decode, ALU and execute control
    apb_issue_port u_port (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .rf      (rf_if.exec)
    );

    // Register storage
    gpr u_gpr (
        .clk   (clk),
        .rst_n (rst_n),
        .rf    (rf_if.regfile)
    );

endmodule

// ==== source/apb_issue_port.sv ====
// APB slave for instruction issue, register and counter reads, execute stage
`timescale 1ns/1ns
`include "core_settings.svh"

module apb_issue_port (
    input  logic                    clk,
    input  logic                    rst_n,
    // APB slave
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [`CORE_APB_AW-1:0] paddr,
    input  logic [`CORE_XLEN-1:0]   pwdata,
    output logic [`CORE_XLEN-1:0]   prdata,
    output logic                    pready,
    output logic                    pslverr,
    // Register file
    gpr_if.exec                     rf
);

    localparam int WIN_BYTES = `CORE_REG_NUM * 4;   // Register window span

    logic [`CORE_XLEN-1:0]      issue_q;        // Issued instruction word
    logic                       exec_valid_q;   // Execute cycle active
    logic [`CORE_RETIRED_W-1:0] retired_q;      // Retired instructions

    logic                       access;
    logic                       hit_instr, hit_retired, hit_gpr;
    logic [`CORE_APB_AW-1:0]    win_off;        // Offset into register window
    logic                       err;
    logic                       instr_accept;
    logic [`CORE_XLEN-1:0]      dec_in;
    core_pkg::decoded_t         dec;
    logic [`CORE_XLEN-1:0]      op_b;
    logic [`CORE_XLEN-1:0]      alu_y;

    //////////////////////////////////////////////////////////////////////
    // APB address decode
    //////////////////////////////////////////////////////////////////////

    assign access      = psel && penable;                // Access phase
    assign win_off     = paddr - `CORE_ADDR_GPR_BASE;
    assign hit_instr   = (paddr == `CORE_ADDR_INSTR);
    assign hit_retired = (paddr == `CORE_ADDR_RETIRED);
    assign hit_gpr     = (paddr >= `CORE_ADDR_GPR_BASE) && (win_off < WIN_BYTES)
                         && (paddr[1:0] == 2'b00);       // Word aligned only

    // Unmapped, read-only written, or bad instruction
    assign err = !(hit_instr || hit_retired || hit_gpr)
               || (pwrite && (hit_retired || hit_gpr))
               || (pwrite && hit_instr && dec.illegal);

    // One wait state while the execute cycle holds rs1_addr
    assign pready  = !(access && exec_valid_q);
    assign pslverr = access && pready && err;

    assign instr_accept = access && pready && pwrite && hit_instr && !dec.illegal;

    always_comb begin
        prdata = '0;                                    // Instr address reads zero
        if (!pwrite) begin
            if (hit_gpr) begin
                prdata = rf.rs1_data;
            end else if (hit_retired) begin
                prdata = {{(`CORE_XLEN-`CORE_RETIRED_W){1'b0}}, retired_q};
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Decode and execute
    //////////////////////////////////////////////////////////////////////

    // Incoming word checked in cycle A, latched word executed in A+1
    assign dec_in = exec_valid_q ? issue_q : pwdata;

    inst_decoder u_dec (
        .inst (dec_in),
        .dec  (dec)
    );

    assign op_b = dec.use_imm ? dec.imm : rf.rs2_data;

    alu u_alu (
        .op (dec.alu_op),
        .a  (rf.rs1_data),
        .b  (op_b),
        .y  (alu_y)
    );

    // rs1 shared with APB register reads
    assign rf.rs1_addr = exec_valid_q ? dec.rs1 : win_off[2 +: `CORE_REG_AW];
    assign rf.rs2_addr = exec_valid_q ? dec.rs2 : '0;
    assign rf.we       = exec_valid_q && (dec.rd != '0);  // x0 never written
    assign rf.wr_addr  = dec.rd;
    assign rf.wr_data  = alu_y;

    always_ff @(posedge clk) begin
        if (instr_accept) begin
            issue_q <= pwdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exec_valid_q <= 1'b0;
            retired_q    <= '0;
        end else begin
            exec_valid_q <= instr_accept;              // Single cycle pulse
            if (exec_valid_q) begin
                retired_q <= retired_q + 1'b1;         // Retire with the write
            end
        end
    end

endmodule

// ==== source/alu.sv ====
// Combinational integer ALU for the RV32I OP and OP-IMM operations
`timescale 1ns/1ns
`include "core_settings.svh"

module alu (
    input  core_pkg::alu_op_e     op,
    input  logic [`CORE_XLEN-1:0] a,    // Operand A, rs1
    input  logic [`CORE_XLEN-1:0] b,    // Operand B, rs2 or imm
    output logic [`CORE_XLEN-1:0] y
);

    localparam int SHW = $clog2(`CORE_XLEN);   // Shift amount bits

    logic [SHW-1:0] shamt;
    logic           lt_s;       // Signed less-than
    logic           lt_u;       // Unsigned less-than

    assign shamt = b[SHW-1:0];  // Upper bits of b ignored
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;

    //////////////////////////////////////////////////////////////////////
    // Result select
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (op)
            core_pkg::ALU_ADD:    y = a + b;
            core_pkg::ALU_SUB:    y = a - b;
            core_pkg::ALU_SLL:    y = a << shamt;
            core_pkg::ALU_SLT:    y = {{(`CORE_XLEN-1){1'b0}}, lt_s};
            core_pkg::ALU_SLTU:   y = {{(`CORE_XLEN-1){1'b0}}, lt_u};
            core_pkg::ALU_XOR:    y = a ^ b;
            core_pkg::ALU_SRL:    y = a >> shamt;
            // Arithmetic shift keeps the sign bit
            core_pkg::ALU_SRA:    y = $unsigned($signed(a) >>> shamt);
            core_pkg::ALU_OR:     y = a | b;
            core_pkg::ALU_AND:    y = a & b;
            core_pkg::ALU_PASS_B: y = b;             // LUI
            default:              y = '0;            // Unused encodings
        endcase
    end

endmodule

// ==== source/inst_decoder.sv ====
// RV32I OP, OP-IMM and LUI instruction decoder with illegal detection
`timescale 1ns/1ns
`include "core_settings.svh"

module inst_decoder (
    input  logic [`CORE_XLEN-1:0] inst,   // Raw instruction word
    output core_pkg::decoded_t    dec
);

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;   // SUB, SRA, SRAI

    core_pkg::opcode_e opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;

    assign opcode = core_pkg::opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // funct3 to ALU op, alt picks SUB / SRA
    function automatic core_pkg::alu_op_e op_from_f3(input logic [2:0] f3, input logic alt);
        core_pkg::alu_op_e op;
        case (f3)
            3'b000:  op = alt ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
            3'b001:  op = core_pkg::ALU_SLL;
            3'b010:  op = core_pkg::ALU_SLT;
            3'b011:  op = core_pkg::ALU_SLTU;
            3'b100:  op = core_pkg::ALU_XOR;
            3'b101:  op = alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
            3'b110:  op = core_pkg::ALU_OR;
            default: op = core_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        // Field defaults, I-type immediate
        dec.rs1     = inst[19:15];
        dec.rs2     = inst[24:20];
        dec.rd      = inst[11:7];
        dec.alu_op  = core_pkg::ALU_ADD;
        dec.use_imm = 1'b0;
        dec.imm     = {{(`CORE_XLEN-12){inst[31]}}, inst[31:20]};
        dec.illegal = 1'b0;

        case (opcode)
            core_pkg::OPC_OP: begin
                dec.alu_op = op_from_f3(funct3, funct7 == F7_ALT);
                // Alt funct7 only for ADD/SUB and SRL/SRA
                if (funct7 == F7_ALT) begin
                    dec.illegal = (funct3 != 3'b000) && (funct3 != 3'b101);
                end else begin
                    dec.illegal = (funct7 != F7_BASE);
                end
            end
            core_pkg::OPC_OP_IMM: begin
                dec.use_imm = 1'b1;
                dec.rs2     = '0;                    // Field is immediate here
                dec.alu_op  = op_from_f3(funct3, (funct3 == 3'b101) && (funct7 == F7_ALT));
                if (funct3 == 3'b001) begin          // SLLI
                    dec.illegal = (funct7 != F7_BASE);
                end else if (funct3 == 3'b101) begin // SRLI / SRAI
                    dec.illegal = (funct7 != F7_BASE) && (funct7 != F7_ALT);
                end
            end
            core_pkg::OPC_LUI: begin
                dec.rs1     = '0;
                dec.rs2     = '0;
                dec.use_imm = 1'b1;
                dec.alu_op  = core_pkg::ALU_PASS_B;
                dec.imm     = {inst[31:12], 12'b0};  // U-type, low bits zero
            end
            default: begin
                dec.illegal = 1'b1;                  // Loads, branches etc. not here
            end
        endcase
    end

endmodule

// ==== source/gpr.sv ====
// 32 x 32-bit general purpose register file, x0 tied to zero, write bypass
`timescale 1ns/1ns
`include "core_settings.svh"

module gpr (
    input  logic clk,
    input  logic rst_n,
    gpr_if.regfile rf        // Two reads, one write
);

    // Storage, no reset on contents
    logic [`CORE_XLEN-1:0] mem [`CORE_REG_NUM];

    //////////////////////////////////////////////////////////////////////
    // Read ports
    //////////////////////////////////////////////////////////////////////

    // Port 0
    // x0 first, then same-cycle write, then array
    assign rf.rs1_data =
        (rf.rs1_addr == '0)                    ? '0         :
        (rf.we && (rf.wr_addr == rf.rs1_addr)) ? rf.wr_data :
                                                 mem[rf.rs1_addr];

    // Port 1, same priority
    assign rf.rs2_data =
        (rf.rs2_addr == '0)                    ? '0         :
        (rf.we && (rf.wr_addr == rf.rs2_addr)) ? rf.wr_data :
                                                 mem[rf.rs2_addr];

    //////////////////////////////////////////////////////////////////////
    // Write port
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        // No writes while held in reset
        if (rst_n && rf.we) begin
            mem[rf.wr_addr] <= rf.wr_data;   // x0 written harmlessly, reads mask it
        end
    end

endmodule

// ==== source/gpr_if.sv ====
// Register file interface with regfile, exec and monitor modports
`timescale 1ns/1ns
`include "core_settings.svh"

interface gpr_if;

    // Read port 0
    logic [`CORE_REG_AW-1:0] rs1_addr;
    logic [`CORE_XLEN-1:0]   rs1_data;

    // Read port 1
    logic [`CORE_REG_AW-1:0] rs2_addr;
    logic [`CORE_XLEN-1:0]   rs2_data;

    // Write port
    logic                    we;
    logic [`CORE_REG_AW-1:0] wr_addr;
    logic [`CORE_XLEN-1:0]   wr_data;

    // Register array side
    modport regfile (
        input  rs1_addr, rs2_addr, we, wr_addr, wr_data,
        output rs1_data, rs2_data
    );

    // Execute side, owns addresses and write port
    modport exec (
        output rs1_addr, rs2_addr, we, wr_addr, wr_data,
        input  rs1_data, rs2_data
    );

    modport monitor (                                   // Observe only
        input rs1_addr, rs1_data, rs2_addr, rs2_data, we, wr_addr, wr_data
    );

endinterface

// ==== source/core_pkg.sv ====
// Opcode, ALU operation and decoded-instruction types
`include "core_settings.svh"

package core_pkg;

    //////////////////////////////////////////////////////////////////////
    // Major opcodes, RV32I encoding of inst[6:0]
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,   // Register-register
        OPC_OP_IMM = 7'b0010011,   // Register-immediate
        OPC_LUI    = 7'b0110111    // Load upper immediate
    } opcode_e;

    //////////////////////////////////////////////////////////////////////
    // ALU operations
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,   // Signed compare
        ALU_SLTU   = 4'd4,   // Unsigned compare
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10   // Operand B straight through, for LUI
    } alu_op_e;

    // One decoded instruction
    typedef struct packed {
        logic [`CORE_REG_AW-1:0] rs1;      // Source 1 index
        logic [`CORE_REG_AW-1:0] rs2;      // Source 2 index
        logic [`CORE_REG_AW-1:0] rd;       // Destination index
        alu_op_e                 alu_op;
        logic                    use_imm;  // Operand B from imm
        logic [`CORE_XLEN-1:0]   imm;      // Sign-extended or upper
        logic                    illegal;  // Unsupported encoding
    } decoded_t;

endpackage

// ==== source/core_settings.svh ====
// Width, register count, APB address map and counter width macros
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// Datapath
//////////////////////////////////////////////////////////////////////
`define CORE_XLEN          32      // Data word width
`define CORE_REG_NUM       32      // General purpose registers
`define CORE_REG_AW        5       // Register index width

//////////////////////////////////////////////////////////////////////
// APB address map
//////////////////////////////////////////////////////////////////////
`define CORE_APB_AW        8       // APB address width

// Instruction issue, write only
`define CORE_ADDR_INSTR    8'h00
`define CORE_ADDR_RETIRED  8'h04   // Retired count, read only

// Register window, x0 at base, xN at base + 4*N
`define CORE_ADDR_GPR_BASE 8'h80

`define CORE_RETIRED_W     16      // Retired counter width

`endif
